// File: design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// **************************************************
// Execute stage sizing
// **************************************************

`define XLEN 32 // Data and address width
`define REG_INDEX_W 5 // Register file index width

// **************************************************
// Multicycle units
// **************************************************

`define MUL_LATENCY 2 // Multiplier pipeline stages
`define DIV_CYCLES `XLEN // One quotient bit per iteration

`endif

// File: design/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_eq, // Compare codes drive the flag only
		alu_ne,
		alu_lt,
		alu_ge,
		alu_ltu,
		alu_geu
	} alu_op_e;

	typedef enum logic [2:0] {
		sel_zero,
		sel_rs1,
		sel_rs2,
		sel_pc,
		sel_imm
	} operand_sel_e;

	typedef enum logic [2:0] {
		cls_arith,
		cls_compare,
		cls_jump,
		cls_branch,
		cls_load,
		cls_store,
		cls_muldiv
	} exec_class_e;

	typedef enum logic [2:0] {
		md_mul,
		md_mulh,
		md_mulhsu,
		md_mulhu,
		md_div,
		md_divu,
		md_rem,
		md_remu
	} muldiv_op_e;

	// **************************************************
	// Decoded request and execute result
	// **************************************************

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1;
		logic [`XLEN-1:0] rs2;
		logic [`XLEN-1:0] imm;
		logic [`REG_INDEX_W-1:0] rd;
		exec_class_e exec_class;
		alu_op_e alu_op;
		operand_sel_e op1_sel;
		operand_sel_e op2_sel;
		muldiv_op_e muldiv_op;
		logic [2:0] mem_width;
		logic mem_signed;
	} exec_req_t;

	typedef struct packed {
		logic [`REG_INDEX_W-1:0] rd;
		logic rd_write;
		logic [`XLEN-1:0] rd_value; // Store data for stores
		logic [`XLEN-1:0] pc_next;
		logic mem_read;
		logic mem_write;
		logic [2:0] mem_width;
		logic mem_signed;
		logic [`XLEN-1:0] mem_address;
	} exec_rsp_t;

endpackage

// File: design/cpu_alu.sv
`include "cpu_defines.svh"

`timescale 1ns/100ps

module cpu_alu import cpu_pkg::*; (
	input alu_op_e i_op,
	input logic [`XLEN-1:0] i_op1,
	input logic [`XLEN-1:0] i_op2,
	output logic [`XLEN-1:0] o_result,
	output logic o_compare_result
);

	logic [$clog2(`XLEN)-1:0] shamt;
	logic signed_lt;
	logic unsigned_lt;
	logic equal;

	assign shamt = i_op2[$clog2(`XLEN)-1:0];
	assign signed_lt = $signed(i_op1) < $signed(i_op2);
	assign unsigned_lt = i_op1 < i_op2;
	assign equal = i_op1 == i_op2;

	always_comb begin
		case (i_op)
			alu_add: o_result = i_op1 + i_op2;
			alu_sub: o_result = i_op1 - i_op2; // Wraps on overflow
			alu_sll: o_result = i_op1 << shamt;
			alu_slt: o_result = {{(`XLEN-1){1'b0}}, signed_lt};
			alu_sltu: o_result = {{(`XLEN-1){1'b0}}, unsigned_lt};
			alu_xor: o_result = i_op1 ^ i_op2;
			alu_srl: o_result = i_op1 >> shamt;
			alu_sra: o_result = $signed(i_op1) >>> shamt; // Keeps sign bit
			alu_or: o_result = i_op1 | i_op2;
			alu_and: o_result = i_op1 & i_op2;
			default: o_result = '0; // Compare codes
		endcase
	end

	// **************************************************
	// Compare flag for set and branch decisions
	// **************************************************

	always_comb begin
		case (i_op)
			alu_eq: o_compare_result = equal;
			alu_ne: o_compare_result = !equal;
			alu_lt,
			alu_slt: o_compare_result = signed_lt;
			alu_ge: o_compare_result = !signed_lt;
			alu_ltu,
			alu_sltu: o_compare_result = unsigned_lt;
			alu_geu: o_compare_result = !unsigned_lt;
			default: o_compare_result = 1'b0;
		endcase
	end

endmodule

// File: design/cpu_multiply.sv
`include "cpu_defines.svh"

`timescale 1ns/100ps

module cpu_multiply import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input muldiv_op_e i_op,
	input logic [`XLEN-1:0] i_op1,
	input logic [`XLEN-1:0] i_op2,
	output logic o_done,
	output logic [`XLEN-1:0] o_result
);

	logic op1_signed;
	logic op2_signed;
	logic signed [`XLEN:0] op1_ext;
	logic signed [`XLEN:0] op2_ext;
	logic signed [2*`XLEN+1:0] product;

	logic [2*`XLEN-1:0] prod_q [`MUL_LATENCY];
	muldiv_op_e op_q [`MUL_LATENCY];
	logic [`MUL_LATENCY-1:0] valid_q;

	// mulhu treats both as unsigned, mulhsu only the second
	assign op1_signed = (i_op == md_mulh) || (i_op == md_mulhsu);
	assign op2_signed = (i_op == md_mulh);
	assign op1_ext = {op1_signed & i_op1[`XLEN-1], i_op1};
	assign op2_ext = {op2_signed & i_op2[`XLEN-1], i_op2};
	assign product = op1_ext * op2_ext;

	always_ff @(posedge i_clock) begin
		prod_q[0] <= product[2*`XLEN-1:0];
		op_q[0] <= i_op;
		for (int i = 1; i < `MUL_LATENCY; i++) begin
			prod_q[i] <= prod_q[i-1];
			op_q[i] <= op_q[i-1];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= i_start;
			for (int i = 1; i < `MUL_LATENCY; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	assign o_done = valid_q[`MUL_LATENCY-1];
	assign o_result = (op_q[`MUL_LATENCY-1] == md_mul) ?
		prod_q[`MUL_LATENCY-1][`XLEN-1:0] : // Low half
		prod_q[`MUL_LATENCY-1][2*`XLEN-1:`XLEN];

endmodule

// File: design/cpu_divide.sv
`include "cpu_defines.svh"

`timescale 1ns/100ps

module cpu_divide import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input muldiv_op_e i_op,
	input logic [`XLEN-1:0] i_numerator,
	input logic [`XLEN-1:0] i_denominator,
	output logic o_done,
	output logic [`XLEN-1:0] o_result
);

	localparam int COUNT_W = $clog2(`DIV_CYCLES + 1);

	logic signed_op;
	logic num_neg;
	logic den_neg;
	logic [`XLEN-1:0] num_mag;
	logic [`XLEN-1:0] den_mag;
	logic [`XLEN:0] trial;
	logic [`XLEN-1:0] quotient;
	logic [`XLEN-1:0] remainder;

	logic running;
	logic [COUNT_W-1:0] count;
	logic [`XLEN-1:0] quo_q; // Dividend bits shift out, quotient bits shift in
	logic [`XLEN-1:0] rem_q;
	logic [`XLEN-1:0] den_q;
	logic [`XLEN-1:0] num_q;
	muldiv_op_e op_q;
	logic neg_quo_q;
	logic neg_rem_q;
	logic div_zero_q;
	logic overflow_q;

	assign signed_op = (i_op == md_div) || (i_op == md_rem);
	assign num_neg = signed_op && i_numerator[`XLEN-1];
	assign den_neg = signed_op && i_denominator[`XLEN-1];
	assign num_mag = num_neg ? -i_numerator : i_numerator;
	assign den_mag = den_neg ? -i_denominator : i_denominator;

	// Shift one dividend bit into the partial remainder and try the subtract
	assign trial = {rem_q, quo_q[`XLEN-1]} - {1'b0, den_q};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			running <= 1'b0;
			count <= '0;
		end else if (i_start) begin
			running <= 1'b1;
			count <= COUNT_W'(`DIV_CYCLES);
		end else if (running) begin
			if (count != '0) count <= count - 1'b1;
			else running <= 1'b0; // Result taken this cycle
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			rem_q <= '0;
			quo_q <= num_mag;
			den_q <= den_mag;
			num_q <= i_numerator;
			op_q <= i_op;
			neg_quo_q <= num_neg ^ den_neg;
			neg_rem_q <= num_neg;
			div_zero_q <= i_denominator == '0;
			overflow_q <= signed_op && (i_numerator == {1'b1, {(`XLEN-1){1'b0}}})
				&& (i_denominator == '1);
		end else if (running && count != '0) begin
			if (!trial[`XLEN]) begin
				rem_q <= trial[`XLEN-1:0];
				quo_q <= {quo_q[`XLEN-2:0], 1'b1};
			end else begin
				rem_q <= {rem_q[`XLEN-2:0], quo_q[`XLEN-1]};
				quo_q <= {quo_q[`XLEN-2:0], 1'b0};
			end
		end
	end

	assign quotient = div_zero_q ? '1 : overflow_q ? num_q :
		neg_quo_q ? -quo_q : quo_q;
	assign remainder = div_zero_q ? num_q : overflow_q ? '0 :
		neg_rem_q ? -rem_q : rem_q; // Takes sign of dividend

	assign o_done = running && (count == '0);
	assign o_result = (op_q == md_div || op_q == md_divu) ? quotient : remainder;

endmodule

// File: design/cpu_stage_reg.sv
`timescale 1ns/100ps

module cpu_stage_reg #(
	parameter type payload_t = logic
) (
	input logic i_clock,
	input logic i_reset,

	input logic i_valid,
	output logic o_ready,
	input payload_t i_data,

	output logic o_valid,
	input logic i_ready,
	output payload_t o_data
);

	logic valid_q;
	payload_t data_q;

	// Empty slot or one that drains this cycle
	assign o_ready = !valid_q || i_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid_q <= 1'b0;
		end else if (o_ready) begin
			valid_q <= i_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (o_ready && i_valid) begin
			data_q <= i_data; // Held under back-pressure
		end
	end

	assign o_valid = valid_q;
	assign o_data = data_q;

endmodule

// File: design/cpu_execute.sv
`include "cpu_defines.svh"

`timescale 1ns/100ps

module cpu_execute import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_req_valid,
	output logic o_req_ready,
	input exec_req_t i_req,

	output logic o_rsp_valid,
	input logic i_rsp_ready,
	output exec_rsp_t o_rsp
);

	function automatic logic [`XLEN-1:0] select_operand(operand_sel_e sel, exec_req_t req);
		case (sel)
			sel_rs1: return req.rs1;
			sel_rs2: return req.rs2;
			sel_pc: return req.pc;
			sel_imm: return req.imm;
			default: return '0;
		endcase
	endfunction

	logic [`XLEN-1:0] alu_op1;
	logic [`XLEN-1:0] alu_op2;
	logic [`XLEN-1:0] alu_result;
	logic alu_compare;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] branch_target;
	logic accept;
	logic is_muldiv;
	exec_rsp_t rsp_next;

	logic rsp_valid_q;
	exec_rsp_t rsp_q;
	logic mdu_busy;
	logic mdu_start;
	logic mdu_is_div;
	muldiv_op_e mdu_op;
	logic [`XLEN-1:0] mdu_op1;
	logic [`XLEN-1:0] mdu_op2;
	exec_rsp_t mdu_rsp; // Response waiting for its rd value
	logic mul_done;
	logic div_done;
	logic mdu_done;
	logic [`XLEN-1:0] mul_result;
	logic [`XLEN-1:0] div_result;
	logic [`XLEN-1:0] mdu_result;

	assign alu_op1 = select_operand(i_req.op1_sel, i_req);
	assign alu_op2 = select_operand(i_req.op2_sel, i_req);
	assign pc_plus4 = i_req.pc + `XLEN'(4);
	assign branch_target = i_req.pc + i_req.imm;

	cpu_alu u_alu (
		.i_op(i_req.alu_op),
		.i_op1(alu_op1),
		.i_op2(alu_op2),
		.o_result(alu_result),
		.o_compare_result(alu_compare)
	);

	// **************************************************
	// Response for the single-cycle classes
	// **************************************************

	always_comb begin
		rsp_next = '0;
		rsp_next.rd = i_req.rd;
		rsp_next.rd_write = 1'b1;
		rsp_next.rd_value = alu_result;
		rsp_next.pc_next = pc_plus4;
		case (i_req.exec_class)
			cls_arith: ;
			cls_compare: rsp_next.rd_value = {{(`XLEN-1){1'b0}}, alu_compare};
			cls_jump: begin
				rsp_next.rd_value = pc_plus4; // Link address
				rsp_next.pc_next = alu_result;
			end
			cls_branch: begin
				rsp_next.rd_write = 1'b0;
				rsp_next.rd_value = '0;
				if (alu_compare) rsp_next.pc_next = branch_target;
			end
			cls_load,
			cls_store: begin
				rsp_next.mem_read = i_req.exec_class == cls_load;
				rsp_next.mem_write = i_req.exec_class == cls_store;
				rsp_next.mem_width = i_req.mem_width;
				rsp_next.mem_signed = i_req.mem_signed;
				rsp_next.mem_address = alu_result;
				rsp_next.rd_write = i_req.exec_class == cls_load;
				rsp_next.rd_value = (i_req.exec_class == cls_store) ? i_req.rs2 : '0;
			end
			default: rsp_next.rd_value = '0; // Filled in by mul/div
		endcase
	end

	assign is_muldiv = i_req.exec_class == cls_muldiv;
	assign o_req_ready = !mdu_busy && (!rsp_valid_q || i_rsp_ready);
	assign accept = i_req_valid && o_req_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rsp_valid_q <= 1'b0;
			mdu_busy <= 1'b0;
			mdu_start <= 1'b0;
		end else begin
			mdu_start <= accept && is_muldiv;
			if (accept && is_muldiv) mdu_busy <= 1'b1;
			else if (mdu_done) mdu_busy <= 1'b0;
			if ((accept && !is_muldiv) || (mdu_busy && mdu_done)) rsp_valid_q <= 1'b1;
			else if (i_rsp_ready) rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept && is_muldiv) begin
			mdu_rsp <= rsp_next;
			mdu_op <= i_req.muldiv_op;
			mdu_is_div <= i_req.muldiv_op inside {md_div, md_divu, md_rem, md_remu};
			mdu_op1 <= i_req.rs1;
			mdu_op2 <= i_req.rs2;
		end
		if (accept && !is_muldiv) begin
			rsp_q <= rsp_next;
		end else if (mdu_busy && mdu_done) begin
			rsp_q <= mdu_rsp;
			rsp_q.rd_value <= mdu_result;
		end
	end

	// **************************************************
	// Multiply and divide units
	// **************************************************

	cpu_multiply u_multiply (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(mdu_start && !mdu_is_div),
		.i_op(mdu_op),
		.i_op1(mdu_op1),
		.i_op2(mdu_op2),
		.o_done(mul_done),
		.o_result(mul_result)
	);

	cpu_divide u_divide (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(mdu_start && mdu_is_div),
		.i_op(mdu_op),
		.i_numerator(mdu_op1),
		.i_denominator(mdu_op2),
		.o_done(div_done),
		.o_result(div_result)
	);

	assign mdu_done = mul_done || div_done; // Only one unit runs at a time
	assign mdu_result = mdu_is_div ? div_result : mul_result;

	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp = rsp_q;

endmodule

// File: design/cpu_execute_top.sv
`timescale 1ns/100ps

module cpu_execute_top import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_req_valid,
	output logic o_req_ready,
	input exec_req_t i_req,

	output logic o_rsp_valid,
	input logic i_rsp_ready,
	output exec_rsp_t o_rsp
);

	exec_req_t req_q;
	logic req_q_valid;
	logic req_q_ready;
	exec_rsp_t rsp_d;
	logic rsp_d_valid;
	logic rsp_d_ready;

	cpu_stage_reg #(.payload_t(exec_req_t)) u_req_slice (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(i_req_valid),
		.o_ready(o_req_ready),
		.i_data(i_req),
		.o_valid(req_q_valid),
		.i_ready(req_q_ready),
		.o_data(req_q)
	);

	cpu_execute u_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req_valid(req_q_valid),
		.o_req_ready(req_q_ready),
		.i_req(req_q),
		.o_rsp_valid(rsp_d_valid),
		.i_rsp_ready(rsp_d_ready),
		.o_rsp(rsp_d)
	);

	cpu_stage_reg #(.payload_t(exec_rsp_t)) u_rsp_slice (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(rsp_d_valid),
		.o_ready(rsp_d_ready),
		.i_data(rsp_d),
		.o_valid(o_rsp_valid),
		.i_ready(i_rsp_ready),
		.o_data(o_rsp)
	);

endmodule

// File: dv/tb_cpu_execute.sv
`include "cpu_defines.svh"

`timescale 1ns/100ps

module tb_cpu_execute import cpu_pkg::*; ();

	logic i_clock;
	logic i_reset;
	logic i_req_valid;
	logic o_req_ready;
	exec_req_t i_req;
	logic o_rsp_valid;
	logic i_rsp_ready;
	exec_rsp_t o_rsp;

	exec_req_t req_table[$];
	exec_rsp_t rsp_table[$];
	logic table_built = 1'b0;
	int seed;
	int rsp_count;

	cpu_execute_top DUT (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req_valid(i_req_valid),
		.o_req_ready(o_req_ready),
		.i_req(i_req),
		.o_rsp_valid(o_rsp_valid),
		.i_rsp_ready(i_rsp_ready),
		.o_rsp(o_rsp)
	);

	always #10 i_clock = ~i_clock; // 20 ns period

	// **************************************************
	// Table entries built from the response rules
	// **************************************************

	function automatic exec_req_t build_request(exec_class_e cls, alu_op_e op,
			logic [`XLEN-1:0] pc, logic [`XLEN-1:0] rs1, logic [`XLEN-1:0] rs2,
			logic [`XLEN-1:0] imm, logic [4:0] rd);
		exec_req_t req;
		req = '0;
		req.exec_class = cls;
		req.alu_op = op;
		req.pc = pc;
		req.rs1 = rs1;
		req.rs2 = rs2;
		req.imm = imm;
		req.rd = rd;
		req.op1_sel = sel_rs1;
		req.op2_sel = sel_rs2;
		req.muldiv_op = md_mul;
		return req;
	endfunction

	function automatic exec_rsp_t build_response(logic [4:0] rd, logic rd_write,
			logic [`XLEN-1:0] value, logic [`XLEN-1:0] pc_next);
		exec_rsp_t rsp;
		rsp = '0; // Memory flags stay low
		rsp.rd = rd;
		rsp.rd_write = rd_write;
		rsp.rd_value = value;
		rsp.pc_next = pc_next;
		return rsp;
	endfunction

	task automatic alu_entry(exec_class_e cls, alu_op_e op, operand_sel_e op1_sel,
			operand_sel_e op2_sel, logic [`XLEN-1:0] rs1, logic [`XLEN-1:0] rs2,
			logic [`XLEN-1:0] imm, logic [4:0] rd, logic [`XLEN-1:0] expected);
		exec_req_t req;
		req = build_request(cls, op, 'h1000, rs1, rs2, imm, rd);
		req.op1_sel = op1_sel;
		req.op2_sel = op2_sel;
		req_table.push_back(req);
		rsp_table.push_back(build_response(rd, 1'b1, expected, 'h1004));
	endtask

	task automatic jump_entry(operand_sel_e op1_sel, logic [`XLEN-1:0] pc,
			logic [`XLEN-1:0] rs1, logic [`XLEN-1:0] imm, logic [4:0] rd,
			logic [`XLEN-1:0] target);
		exec_req_t req;
		req = build_request(cls_jump, alu_add, pc, rs1, '0, imm, rd);
		req.op1_sel = op1_sel;
		req.op2_sel = sel_imm;
		req_table.push_back(req);
		rsp_table.push_back(build_response(rd, 1'b1, pc + 32'd4, target)); // Link address
	endtask

	task automatic branch_entry(alu_op_e op, logic [`XLEN-1:0] pc, logic [`XLEN-1:0] rs1,
			logic [`XLEN-1:0] rs2, logic [`XLEN-1:0] imm, logic taken);
		req_table.push_back(build_request(cls_branch, op, pc, rs1, rs2, imm, 5'd0));
		rsp_table.push_back(build_response(5'd0, 1'b0, '0, taken ? pc + imm : pc + 32'd4));
	endtask

	task automatic mem_entry(logic store, logic [`XLEN-1:0] rs1, logic [`XLEN-1:0] rs2,
			logic [`XLEN-1:0] imm, logic [2:0] width, logic sgn, logic [4:0] rd,
			logic [`XLEN-1:0] address);
		exec_req_t req;
		exec_rsp_t rsp;
		req = build_request(cls_load, alu_add, 'h6000, rs1, rs2, imm, rd);
		if (store) req.exec_class = cls_store;
		req.op2_sel = sel_imm;
		req.mem_width = width;
		req.mem_signed = sgn;
		rsp = build_response(rd, !store, store ? rs2 : '0, 'h6004); // Store data rides in rd value
		rsp.mem_read = !store;
		rsp.mem_write = store;
		rsp.mem_width = width;
		rsp.mem_signed = sgn;
		rsp.mem_address = address;
		req_table.push_back(req);
		rsp_table.push_back(rsp);
	endtask

	task automatic muldiv_entry(muldiv_op_e op, logic [`XLEN-1:0] rs1, logic [`XLEN-1:0] rs2,
			logic [4:0] rd, logic [`XLEN-1:0] expected);
		exec_req_t req;
		req = build_request(cls_muldiv, alu_add, 'h7000, rs1, rs2, '0, rd);
		req.muldiv_op = op;
		req_table.push_back(req);
		rsp_table.push_back(build_response(rd, 1'b1, expected, 'h7004));
	endtask

	// **************************************************
	// Checks
	// **************************************************

	task automatic stop_on_failure();
		$display("sim failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_field(int idx, string name, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR at %0t: entry %0d %s expected %h, got %h",
				$time, idx, name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_response(int idx, exec_rsp_t got);
		exec_rsp_t exp;
		exp = rsp_table[idx];
		check_field(idx, "rd", 32'(exp.rd), 32'(got.rd));
		check_field(idx, "rd_write", 32'(exp.rd_write), 32'(got.rd_write));
		check_field(idx, "rd_value", exp.rd_value, got.rd_value);
		check_field(idx, "pc_next", exp.pc_next, got.pc_next);
		check_field(idx, "mem_read", 32'(exp.mem_read), 32'(got.mem_read));
		check_field(idx, "mem_write", 32'(exp.mem_write), 32'(got.mem_write));
		check_field(idx, "mem_width", 32'(exp.mem_width), 32'(got.mem_width));
		check_field(idx, "mem_signed", 32'(exp.mem_signed), 32'(got.mem_signed));
		check_field(idx, "mem_address", exp.mem_address, got.mem_address);
	endtask

	task automatic drive_requests();
		int gap;
		for (int i = 0; i < req_table.size(); i++) begin
			gap = {$random(seed)} % 3; // Idle cycles before this request
			i_req_valid = 1'b0;
			repeat (gap) @(negedge i_clock);
			i_req = req_table[i];
			i_req_valid = 1'b1;
			@(posedge i_clock);
			while (!o_req_ready) @(posedge i_clock);
			@(negedge i_clock);
		end
		i_req_valid = 1'b0;
	endtask

	task automatic collect_responses();
		while (rsp_count < rsp_table.size()) begin
			@(negedge i_clock);
			i_rsp_ready = ({$random(seed)} % 4) != 0; // Ready about three cycles in four
			@(posedge i_clock);
			if (o_rsp_valid && i_rsp_ready) begin
				check_response(rsp_count, o_rsp);
				rsp_count++;
			end
		end
	endtask

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_req_valid = 1'b0;
		i_req = '0;
		i_rsp_ready = 1'b0;
		seed = 34286;
		rsp_count = 0;

		// Arithmetic with register, immediate and PC operands
		alu_entry(cls_arith, alu_add, sel_rs1, sel_rs2, 'h7fff_ffff, 'h1, 'h0, 5'd1, 'h8000_0000);
		alu_entry(cls_arith, alu_sub, sel_rs1, sel_rs2, 'h0, 'h1, 'h0, 5'd2, 'hffff_ffff);
		alu_entry(cls_arith, alu_sll, sel_rs1, sel_rs2, 'h1, 'h24, 'h0, 5'd3, 'h10);
		alu_entry(cls_arith, alu_sra, sel_rs1, sel_imm, 'hf000_0000, 'h0, 'h4, 5'd4, 'hff00_0000);
		alu_entry(cls_arith, alu_srl, sel_rs1, sel_rs2, 'hf000_0000, 'h4, 'h0, 5'd5, 'h0f00_0000);
		alu_entry(cls_arith, alu_slt, sel_rs1, sel_rs2, 'hffff_ffff, 'h1, 'h0, 5'd6, 'h1);
		alu_entry(cls_arith, alu_sltu, sel_rs1, sel_rs2, 'hffff_ffff, 'h1, 'h0, 5'd7, 'h0);
		alu_entry(cls_arith, alu_xor, sel_rs1, sel_rs2, 'ha5a5_a5a5, 'hffff_0000, 'h0, 5'd8,
			'h5a5a_a5a5);
		alu_entry(cls_arith, alu_or, sel_rs1, sel_imm, 'hf0f0_f0f0, 'h0, 'h0f00_00ff, 5'd9,
			'hfff0_f0ff);
		alu_entry(cls_arith, alu_and, sel_rs1, sel_rs2, 'hf0f0_f0f0, 'h3c3c_3c3c, 'h0, 5'd10,
			'h3030_3030);
		alu_entry(cls_arith, alu_add, sel_pc, sel_imm, 'h0, 'h0, 'h1_2000, 5'd11, 'h1_3000);
		alu_entry(cls_arith, alu_add, sel_zero, sel_imm, 'h5, 'h6, 'habcd_e000, 5'd12, 'habcd_e000);
		alu_entry(cls_compare, alu_lt, sel_rs1, sel_rs2, 'h8000_0000, 'h7fff_ffff, 'h0, 5'd13, 'h1);
		alu_entry(cls_compare, alu_ltu, sel_rs1, sel_rs2, 'h8000_0000, 'h7fff_ffff, 'h0, 5'd14, 'h0);
		jump_entry(sel_pc, 'h3000, 'h0, 'hffff_ff00, 5'd1, 'h2f00);
		jump_entry(sel_rs1, 'h3100, 'h4000, 'h10, 5'd5, 'h4010);
		branch_entry(alu_eq, 'h5000, 'h1234_5678, 'h1234_5678, 'h40, 1'b1);
		branch_entry(alu_ne, 'h5000, 'h1234_5678, 'h1234_5678, 'h40, 1'b0);
		branch_entry(alu_lt, 'h5000, 'hffff_fffe, 'h1, 'h40, 1'b1);
		branch_entry(alu_ge, 'h5000, 'hffff_fffe, 'h1, 'h40, 1'b0);
		branch_entry(alu_ltu, 'h5100, 'hffff_fffe, 'h1, 'hffff_fff0, 1'b0);
		branch_entry(alu_geu, 'h5100, 'hffff_fffe, 'h1, 'hffff_fff0, 1'b1);
		muldiv_entry(md_mul, 'hffff_fffd, 'h7, 5'd15, 'hffff_ffeb);
		muldiv_entry(md_mulh, 'hffff_ffff, 'hffff_ffff, 5'd16, 'h0);
		muldiv_entry(md_mulh, 'h8000_0000, 'h8000_0000, 5'd17, 'h4000_0000);
		muldiv_entry(md_mulhsu, 'hffff_ffff, 'hffff_ffff, 5'd18, 'hffff_ffff);
		muldiv_entry(md_mulhu, 'hffff_ffff, 'hffff_ffff, 5'd19, 'hffff_fffe);
		mem_entry(1'b0, 'h1_0000, 'h0, 'hffff_fffc, 3'd2, 1'b1, 5'd7, 'hfffc); // Word load
		mem_entry(1'b0, 'h2000, 'h0, 'h3, 3'd0, 1'b0, 5'd8, 'h2003);
		mem_entry(1'b1, 'h3000, 'hcafe_babe, 'h6, 3'd1, 1'b0, 5'd0, 'h3006); // Half store
		muldiv_entry(md_div, 'hffff_ffec, 'h3, 5'd20, 'hffff_fffa);
		muldiv_entry(md_rem, 'hffff_ffec, 'h3, 5'd21, 'hffff_fffe);
		muldiv_entry(md_divu, 'hffff_ffec, 'h3, 5'd22, 'h5555_554e);
		muldiv_entry(md_remu, 'hffff_ffec, 'h3, 5'd23, 'h2);
		muldiv_entry(md_div, 'h1234, 'h0, 5'd24, 'hffff_ffff);
		muldiv_entry(md_rem, 'h1234, 'h0, 5'd25, 'h1234);
		muldiv_entry(md_div, 'h8000_0000, 'hffff_ffff, 5'd26, 'h8000_0000);
		muldiv_entry(md_rem, 'h8000_0000, 'hffff_ffff, 5'd27, 'h0);
		table_built = 1'b1;

		repeat (8) begin
			@(negedge i_clock);
			assert (!o_rsp_valid) else begin
				$display("Response valid was seen while reset was held");
				stop_on_failure();
			end
		end
		i_reset = 1'b0;

		fork
			drive_requests();
			collect_responses();
		join

		// Nothing may follow the last response
		@(negedge i_clock);
		i_rsp_ready = 1'b1;
		repeat (`DIV_CYCLES + 10) begin
			@(posedge i_clock);
			assert (!o_rsp_valid) else begin
				$display("A response arrived after the last table entry was matched");
				stop_on_failure();
			end
		end
		$display("sim passed");
		$finish;
	end

	initial begin
		wait (table_built);
		#((8 + rsp_table.size() * (`DIV_CYCLES + 10)) * 20);
		$display("Timeout: responses stopped arriving after %0d of %0d",
			rsp_count, rsp_table.size());
		stop_on_failure();
	end

endmodule

// File: src.f
+incdir+design
design/cpu_pkg.sv
design/cpu_alu.sv
design/cpu_multiply.sv
design/cpu_divide.sv
design/cpu_stage_reg.sv
design/cpu_execute.sv
design/cpu_execute_top.sv
dv/tb_cpu_execute.sv

// File: Makefile
SRCS := src.f $(wildcard design/*.sv design/*.svh dv/*.sv)

all: run

obj_dir/Vtb_cpu_execute: $(SRCS)
	verilator --binary --timing --assert --top-module tb_cpu_execute -f src.f

run: obj_dir/Vtb_cpu_execute
	./obj_dir/Vtb_cpu_execute > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
